//--- build.f
hw/rvseed_pkg.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/id_ex_regs.sv
hw/alu_exec.sv
hw/wb_stage.sv
hw/rvseed_core.sv
testbench/tb_rvseed_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_rvseed_core -o sim_rvseed \
        > build.log 2>&1 \
    && ./obj_dir/sim_rvseed > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

//--- testbench/tb_rvseed_core.sv
`timescale 1ns/1ns

module tb_rvseed_core;

    localparam logic [63:0] RESET_PC   = 64'h8000_0000;
    localparam int          MAX_CYCLES = 2000;   // tests need under 100 cycles
    localparam logic [31:0] EBREAK     = 32'h0010_0073;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        ebreak;
        logic [4:0]  addr;
        logic [63:0] data;
        logic [63:0] pc;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        wb_valid_o;
    logic [4:0]  wb_addr_o;
    logic [63:0] wb_data_o;
    logic [63:0] wb_pc_o;
    logic        illegal_o;
    logic        halted_o;

    logic [63:0] model_regs [32];
    logic [63:0] model_pc;
    logic        model_stopped;
    logic        halt_seen;
    exp_t        pipe [2];   // in flight with [1] due now
    logic [31:0] lfsr;
    int          cycles = 0;
    int          errors;
    int          checks;
    int          tests;
    int          err_base;

    rvseed_core #(.RESET_PC(RESET_PC)) dut_i (
        .clk(clk), .rst_n(rst_n), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o),
        .wb_pc_o(wb_pc_o), .illegal_o(illegal_o), .halted_o(halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // expected writeback from the isa rules and the model registers
    function automatic exp_t predict(input logic [31:0] w);
        exp_t        e;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        e       = '0;
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        imm     = {{52{w[31]}}, w[31:20]};
        e.valid = 1'b1;
        e.addr  = w[11:7];
        e.pc    = model_pc;
        case (w[6:0])
            7'b0110011: begin
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: e.data = a + b;
                    10'b0100000_000: e.data = a - b;
                    10'b0000000_001: e.data = a << b[5:0];
                    10'b0000000_010: e.data = {63'd0, $signed(a) < $signed(b)};
                    10'b0000000_011: e.data = {63'd0, a < b};
                    10'b0000000_100: e.data = a ^ b;
                    10'b0000000_101: e.data = a >> b[5:0];
                    10'b0100000_101: e.data = $signed(a) >>> b[5:0];
                    10'b0000000_110: e.data = a | b;
                    10'b0000000_111: e.data = a & b;
                    default:         e.illegal = 1'b1;
                endcase
            end
            7'b0010011: begin
                case (w[14:12])
                    3'b000:  e.data = a + imm;
                    3'b100:  e.data = a ^ imm;
                    3'b110:  e.data = a | imm;
                    3'b111:  e.data = a & imm;
                    default: e.illegal = 1'b1;
                endcase
            end
            7'b0110111: e.data = {{32{w[31]}}, w[31:12], 12'h000};
            7'b1110011: begin
                e.ebreak  = (w == EBREAK);
                e.illegal = (w != EBREAK);
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal || e.ebreak || e.addr == 5'd0)
            e.valid = 1'b0;   // nothing reaches the register file
        return e;
    endfunction

    task automatic expect_eq(input logic [63:0] got, input logic [63:0] want,
                             input string what);
        checks++;
        assert (got === want)
        else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    // check the result that is due and drive the next input
    task automatic step(input logic valid, input logic [31:0] w, input exp_t e);
        @(posedge clk);
        #10;
        if (pipe[1].ebreak)
            halt_seen = 1'b1;
        expect_eq(64'(wb_valid_o), 64'(pipe[1].valid), "wb_valid_o");
        expect_eq(64'(illegal_o), 64'(pipe[1].illegal), "illegal_o");
        expect_eq(64'(halted_o), 64'(halt_seen), "halted_o");
        if (pipe[1].valid) begin
            expect_eq(64'(wb_addr_o), 64'(pipe[1].addr), "wb_addr_o");
            expect_eq(wb_data_o, pipe[1].data, "wb_data_o");
            expect_eq(wb_pc_o, pipe[1].pc, "wb_pc_o");
        end
        pipe[1]      = pipe[0];
        pipe[0]      = e;
        inst_valid_i = valid;
        inst_i       = w;
    endtask

    task automatic issue(input logic [31:0] w);
        exp_t e;
        e = '0;
        if (!model_stopped) begin   // strobes after ebreak are dropped
            e = predict(w);
            if (e.valid)
                model_regs[e.addr] = e.data;
            model_stopped = e.ebreak;
            model_pc      = model_pc + 64'd4;
        end
        step(1'b1, w, e);
    endtask

    task automatic end_test(input string name);
        for (int i = 0; i < 3; i++)
            step(1'b0, 32'h0, '0);   // drain the pipeline
        tests++;
        $display("test %s finished, %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    task automatic reset_and_pc();
        expect_eq(64'({wb_valid_o, illegal_o, halted_o, wb_addr_o}), 64'd0, "flags after reset");
        expect_eq(wb_data_o, 64'd0, "wb_data_o after reset");
        expect_eq(wb_pc_o, 64'd0, "wb_pc_o after reset");
        for (int i = 1; i <= 4; i++)
            issue(imm_word(3'b000, 5'(i), 5'd0, 12'(i)));
        end_test("reset_and_pc");
    endtask

    task automatic alu_results();
        logic [9:0] r_ops [10];
        r_ops = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_001, 10'b0000000_010,
                  10'b0000000_011, 10'b0000000_100, 10'b0000000_101, 10'b0100000_101,
                  10'b0000000_110, 10'b0000000_111};
        for (int r = 1; r <= 8; r++) begin
            if (r % 2 == 1)
                issue(imm_word(3'b000, 5'(r), 5'd0, 12'(rand_bits(12))));
            else
                issue(lui_word(5'(r), 20'(rand_bits(20))));
        end
        foreach (r_ops[k])
            issue(r_word(r_ops[k][9:3], r_ops[k][2:0], 5'(rand_bits(5)),
                         5'(rand_bits(3)) + 5'd1, 5'(rand_bits(3)) + 5'd1));
        issue(imm_word(3'b000, 5'd9, 5'd0, 12'hfff));           // x9 = -1
        issue(imm_word(3'b000, 5'd10, 5'd0, 12'd3));
        issue(r_word(7'b0000000, 3'b010, 5'd11, 5'd9, 5'd10));  // slt sees -1 < 3
        issue(r_word(7'b0000000, 3'b011, 5'd12, 5'd9, 5'd10));  // sltu sees max > 3
        issue(r_word(7'b0100000, 3'b101, 5'd13, 5'd9, 5'd10));  // sign fill
        issue(r_word(7'b0000000, 3'b101, 5'd14, 5'd9, 5'd10));  // zero fill
        end_test("alu_results");
    endtask

    task automatic forward_paths();
        issue(imm_word(3'b000, 5'd5, 5'd0, 12'(rand_bits(12))));
        issue(r_word(7'b0000000, 3'b000, 5'd6, 5'd5, 5'd5));   // distance 1
        issue(imm_word(3'b100, 5'd7, 5'd6, 12'(rand_bits(12))));
        issue(imm_word(3'b110, 5'd8, 5'd0, 12'(rand_bits(12))));
        issue(r_word(7'b0100000, 3'b000, 5'd9, 5'd7, 5'd8));   // x7 at distance 2
        step(1'b0, 32'h0, '0);
        issue(imm_word(3'b111, 5'd10, 5'd9, 12'(rand_bits(12))));   // across a bubble
        issue(imm_word(3'b000, 5'd11, 5'd0, 12'd1));
        issue(imm_word(3'b000, 5'd11, 5'd11, 12'd2));
        issue(imm_word(3'b000, 5'd12, 5'd11, 12'd0));   // youngest x11 wins
        end_test("forward_paths");
    endtask

    task automatic zero_register();
        issue(imm_word(3'b000, 5'd0, 5'd0, 12'(rand_bits(12))));
        issue(lui_word(5'd0, 20'(rand_bits(20))));
        issue(r_word(7'b0000000, 3'b110, 5'd15, 5'd0, 5'd0));
        issue(imm_word(3'b000, 5'd16, 5'd0, 12'd0));
        end_test("zero_register");
    endtask

    task automatic illegal_opcode();
        issue({12'h123, 5'd1, 3'b011, 5'd3, 7'b0000011});       // ld
        issue(32'hffff_ffff);
        issue(r_word(7'b0000001, 3'b000, 5'd4, 5'd1, 5'd2));    // mul
        issue(imm_word(3'b000, 5'd17, 5'd3, 12'd0));            // reads old x3
        issue(imm_word(3'b000, 5'd18, 5'd4, 12'd0));
        end_test("illegal_opcode");
    endtask

    task automatic ebreak_halt();
        issue(imm_word(3'b000, 5'd19, 5'd0, 12'd42));
        issue(EBREAK);
        issue(imm_word(3'b000, 5'd20, 5'd0, 12'd7));
        for (int i = 0; i < 4; i++)
            step(1'b0, 32'h0, '0);
        issue(r_word(7'b0000000, 3'b000, 5'd21, 5'd19, 5'd19));
        end_test("ebreak_halt");
        expect_eq(64'(halted_o), 64'd1, "halted_o after drain");
    endtask

    initial begin
        rst_n         = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        lfsr          = 32'h5a6;
        model_pc      = RESET_PC;
        model_stopped = 1'b0;
        halt_seen     = 1'b0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        err_base      = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 2; i++)
            pipe[i] = '0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        reset_and_pc();
        alu_results();
        forward_paths();
        zero_register();
        illegal_opcode();
        ebreak_halt();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- hw/rvseed_core.sv
`timescale 1ns/1ns

module rvseed_core #(
    parameter logic [rvseed_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              inst_valid_i,
    input  logic [rvseed_pkg::INST_W-1:0]     inst_i,
    output logic                              wb_valid_o,
    output logic [rvseed_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [rvseed_pkg::XLEN-1:0]       wb_data_o,
    output logic [rvseed_pkg::XLEN-1:0]       wb_pc_o,
    output logic                              illegal_o,
    output logic                              halted_o
);

    logic [rvseed_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rvseed_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rvseed_pkg::XLEN-1:0]       rs1_data;
    logic [rvseed_pkg::XLEN-1:0]       rs2_data;
    rvseed_pkg::id_ex_t                id_bundle;
    rvseed_pkg::id_ex_t                ex_bundle;
    rvseed_pkg::wb_t                   ex_result;
    rvseed_pkg::wb_t                   wb_rec;
    rvseed_pkg::bypass_t               ex_byp;
    rvseed_pkg::bypass_t               wb_byp;
    logic                              rf_we;
    logic [rvseed_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [rvseed_pkg::XLEN-1:0]       rf_wdata;

    inst_decode #(
        .RESET_PC (RESET_PC)
    ) u_inst_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ex_byp_i     (ex_byp),
        .wb_byp_i     (wb_byp),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .id_ex_o      (id_bundle)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex_regs #(
        .RESET_PC (RESET_PC)
    ) u_id_ex_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_ex_i (id_bundle),
        .id_ex_o (ex_bundle)
    );

    alu_exec u_alu_exec (
        .id_ex_i  (ex_bundle),
        .result_o (ex_result),
        .ex_byp_o (ex_byp)
    );

    wb_stage u_wb_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .result_i   (ex_result),
        .ena_i      (ex_bundle.ena),
        .wb_o       (wb_rec),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .wb_byp_o   (wb_byp),
        .halted_o   (halted_o),
        .illegal_o  (illegal_o)
    );

    assign wb_valid_o = wb_rec.valid;
    assign wb_addr_o  = wb_rec.addr;
    assign wb_data_o  = wb_rec.data;
    assign wb_pc_o    = wb_rec.pc;

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ns

module wb_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  rvseed_pkg::wb_t                   result_i,
    input  logic                              ena_i,
    output rvseed_pkg::wb_t                   wb_o,
    output logic                              rf_we_o,
    output logic [rvseed_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [rvseed_pkg::XLEN-1:0]       rf_wdata_o,
    output rvseed_pkg::bypass_t               wb_byp_o,
    output logic                              halted_o,
    output logic                              illegal_o
);

    rvseed_pkg::wb_t wb_q;
    logic            halted_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q     <= '0;
            halted_q <= 1'b0;
        end else begin
            wb_q         <= result_i;
            wb_q.ebreak  <= result_i.ebreak & ena_i;    // flags only count for real slots
            wb_q.illegal <= result_i.illegal & ena_i;
            if (ena_i && result_i.ebreak)
                halted_q <= 1'b1;   // sticky until reset
        end
    end

    assign wb_o       = wb_q;
    assign rf_we_o    = wb_q.valid;
    assign rf_waddr_o = wb_q.addr;
    assign rf_wdata_o = wb_q.data;
    assign wb_byp_o   = '{valid: wb_q.valid, addr: wb_q.addr, data: wb_q.data};
    assign halted_o   = halted_q;
    assign illegal_o  = wb_q.illegal;   // one cycle pulse

endmodule

//--- hw/alu_exec.sv
`timescale 1ns/1ns

module alu_exec (
    input  rvseed_pkg::id_ex_t  id_ex_i,
    output rvseed_pkg::wb_t     result_o,
    output rvseed_pkg::bypass_t ex_byp_o
);

    logic [rvseed_pkg::XLEN-1:0] src1;
    logic [rvseed_pkg::XLEN-1:0] src2;
    logic [5:0]                  shamt;   // rv64 shifts use six bits
    logic [rvseed_pkg::XLEN-1:0] alu_res;
    logic                        wr_valid;

    assign src1  = id_ex_i.alu_src1;
    assign src2  = id_ex_i.alu_src2;
    assign shamt = src2[5:0];

    always_comb begin
        case (id_ex_i.alu_op)
            rvseed_pkg::ALU_ADD:    alu_res = src1 + src2;
            rvseed_pkg::ALU_SUB:    alu_res = src1 - src2;
            rvseed_pkg::ALU_AND:    alu_res = src1 & src2;
            rvseed_pkg::ALU_OR:     alu_res = src1 | src2;
            rvseed_pkg::ALU_XOR:    alu_res = src1 ^ src2;
            rvseed_pkg::ALU_SLL:    alu_res = src1 << shamt;
            rvseed_pkg::ALU_SRL:    alu_res = src1 >> shamt;
            rvseed_pkg::ALU_SRA:    alu_res = $signed(src1) >>> shamt;
            rvseed_pkg::ALU_SLT: begin
                alu_res = {63'd0, $signed(src1) < $signed(src2)};
            end
            rvseed_pkg::ALU_SLTU:   alu_res = {63'd0, src1 < src2};
            rvseed_pkg::ALU_PASS_B: alu_res = src2;
            default:                alu_res = '0;
        endcase
    end

    // bubbles carry stale operands, only ena makes a write real
    assign wr_valid = id_ex_i.ena & id_ex_i.reg_wen;

    always_comb begin
        result_o.valid   = wr_valid;
        result_o.addr    = id_ex_i.reg_waddr;
        result_o.data    = alu_res;
        result_o.pc      = id_ex_i.pc;
        result_o.ebreak  = id_ex_i.ebreak_flag;
        result_o.illegal = id_ex_i.illegal_flag;
    end

    always_comb begin
        ex_byp_o.valid = wr_valid;
        ex_byp_o.addr  = id_ex_i.reg_waddr;
        ex_byp_o.data  = alu_res;
    end

endmodule

//--- hw/id_ex_regs.sv
`timescale 1ns/1ns

module id_ex_regs #(
    parameter logic [rvseed_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  rvseed_pkg::id_ex_t id_ex_i,
    output rvseed_pkg::id_ex_t id_ex_o
);

    // no stall or flush, so the bundle moves every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_o    <= '0;
            id_ex_o.pc <= RESET_PC;   // matches decode pc after reset
        end else begin
            id_ex_o <= id_ex_i;
        end
    end

endmodule

//--- hw/inst_decode.sv
`timescale 1ns/1ns

module inst_decode #(
    parameter logic [rvseed_pkg::XLEN-1:0] RESET_PC = 64'h8000_0000
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  inst_valid_i,
    input  logic [rvseed_pkg::INST_W-1:0]         inst_i,
    input  logic [rvseed_pkg::XLEN-1:0]           rs1_data_i,
    input  logic [rvseed_pkg::XLEN-1:0]           rs2_data_i,
    input  rvseed_pkg::bypass_t                   ex_byp_i,
    input  rvseed_pkg::bypass_t                   wb_byp_i,
    output logic [rvseed_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [rvseed_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    output rvseed_pkg::id_ex_t                    id_ex_o
);

    // major opcodes that this core understands
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic [rvseed_pkg::XLEN-1:0]       pc_q;
    logic                              stopped_q;   // set once ebreak seen
    opcode_e                           opcode;
    logic [2:0]                        funct3;
    logic [6:0]                        funct7;
    logic [rvseed_pkg::REG_ADDR_W-1:0] rd;
    logic [rvseed_pkg::XLEN-1:0]       i_imm;
    logic [rvseed_pkg::XLEN-1:0]       u_imm;
    logic [rvseed_pkg::XLEN-1:0]       rs1_val;
    logic [rvseed_pkg::XLEN-1:0]       rs2_val;
    rvseed_pkg::alu_op_e               alu_op;
    logic                              legal;
    logic                              is_ebreak;
    logic                              use_imm;
    logic                              is_lui;
    logic                              ena;

    // youngest producer wins, x0 never forwards
    function automatic logic [rvseed_pkg::XLEN-1:0] fwd(
        input logic [rvseed_pkg::REG_ADDR_W-1:0] addr,
        input logic [rvseed_pkg::XLEN-1:0]       rf_data,
        input rvseed_pkg::bypass_t               ex_byp,
        input rvseed_pkg::bypass_t               wb_byp
    );
        logic [rvseed_pkg::XLEN-1:0] val;
        val = rf_data;
        if (addr != '0) begin
            if (ex_byp.valid && ex_byp.addr == addr)
                val = ex_byp.data;
            else if (wb_byp.valid && wb_byp.addr == addr)
                val = wb_byp.data;
        end
        return val;
    endfunction

    assign opcode     = opcode_e'(inst_i[6:0]);
    assign rd         = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign i_imm      = {{52{inst_i[31]}}, inst_i[31:20]};
    assign u_imm      = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
    assign rs1_val    = fwd(rs1_addr_o, rs1_data_i, ex_byp_i, wb_byp_i);
    assign rs2_val    = fwd(rs2_addr_o, rs2_data_i, ex_byp_i, wb_byp_i);
    assign ena        = inst_valid_i & ~stopped_q;

    always_comb begin
        alu_op    = rvseed_pkg::ALU_ADD;
        legal     = 1'b0;
        is_ebreak = 1'b0;
        use_imm   = 1'b0;
        is_lui    = 1'b0;
        case (opcode)
            OPC_OP: begin
                legal = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = rvseed_pkg::ALU_ADD;
                    10'b0100000_000: alu_op = rvseed_pkg::ALU_SUB;
                    10'b0000000_001: alu_op = rvseed_pkg::ALU_SLL;
                    10'b0000000_010: alu_op = rvseed_pkg::ALU_SLT;
                    10'b0000000_011: alu_op = rvseed_pkg::ALU_SLTU;
                    10'b0000000_100: alu_op = rvseed_pkg::ALU_XOR;
                    10'b0000000_101: alu_op = rvseed_pkg::ALU_SRL;
                    10'b0100000_101: alu_op = rvseed_pkg::ALU_SRA;
                    10'b0000000_110: alu_op = rvseed_pkg::ALU_OR;
                    10'b0000000_111: alu_op = rvseed_pkg::ALU_AND;
                    default:         legal  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                case (funct3)
                    3'b000:  alu_op = rvseed_pkg::ALU_ADD;
                    3'b100:  alu_op = rvseed_pkg::ALU_XOR;
                    3'b110:  alu_op = rvseed_pkg::ALU_OR;
                    3'b111:  alu_op = rvseed_pkg::ALU_AND;
                    default: legal  = 1'b0;   // slti and shifts not supported
                endcase
            end
            OPC_LUI: begin
                legal  = 1'b1;
                is_lui = 1'b1;
                alu_op = rvseed_pkg::ALU_PASS_B;
            end
            OPC_SYSTEM: begin
                is_ebreak = (inst_i == EBREAK_WORD);
                legal     = is_ebreak;   // csr forms fall through as illegal
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        id_ex_o              = '0;
        id_ex_o.pc           = pc_q;
        id_ex_o.ena          = ena;
        id_ex_o.reg_wen      = legal & ~is_ebreak & (rd != '0);
        id_ex_o.reg_waddr    = rd;
        id_ex_o.alu_op       = alu_op;
        id_ex_o.alu_src1     = is_lui ? '0 : rs1_val;
        id_ex_o.alu_src2     = is_lui ? u_imm : (use_imm ? i_imm : rs2_val);
        id_ex_o.ebreak_flag  = is_ebreak;
        id_ex_o.illegal_flag = ~legal;
        id_ex_o.inst         = inst_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q      <= RESET_PC;
            stopped_q <= 1'b0;
        end else if (ena) begin
            pc_q <= pc_q + 64'd4;   // one word per accepted strobe
            if (is_ebreak)
                stopped_q <= 1'b1;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rvseed_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rvseed_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                              we_i,
    input  logic [rvseed_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rvseed_pkg::XLEN-1:0]       wdata_i,
    output logic [rvseed_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rvseed_pkg::XLEN-1:0]       rs2_data_o
);

    localparam int NUM_REGS = 2 ** rvseed_pkg::REG_ADDR_W;

    logic [rvseed_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we_i && waddr_i != '0) begin   // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read, bypass logic sits in decode
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- hw/rvseed_pkg.sv
package rvseed_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // ALU operations, decoded once in ID and carried to EX
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10   // lui result
    } alu_op_e;

    // decoded bundle held in the ID/EX register
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  ena;           // valid instruction in this slot
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       alu_src1;      // operands after forwarding
        logic [XLEN-1:0]       alu_src2;
        logic                  ebreak_flag;
        logic                  illegal_flag;
        logic [INST_W-1:0]     inst;          // raw word, kept for debug
    } id_ex_t;

    // forwarding source seen by decode
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } bypass_t;

    // result record between EX and WB
    typedef struct packed {
        logic                  valid;         // register write happens
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       pc;
        logic                  ebreak;
        logic                  illegal;
    } wb_t;

endpackage
